/* sc_datapath.f */
verilog/datapath_pkg.sv
verilog/fetch_stage.sv
verilog/scoreboard.sv
verilog/execute.sv
verilog/writeback.sv
verilog/dp_control_regs.sv
verilog/sc_datapath.sv
testbench/tb_memory.sv
testbench/sc_datapath_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module sc_datapath_tb \
    -f sc_datapath.f -o sc_datapath_sim

./obj_dir/sc_datapath_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
grep -q "test passed" sim.log

/* testbench/sc_datapath_tb.sv */
// testbench for the datapath: clock, reset, APB stimulus, assertions and timeout
`timescale 1ns/100ps
module sc_datapath_tb;
    import datapath_pkg::*;

    localparam int    CYCLE_LIMIT = 3000;
    localparam word_t START_PC    = 32'h100;
    // values the program builds, by the RV32I rules
    localparam word_t V1   = 32'd5;
    localparam word_t V2   = V1 + 32'd7;
    localparam word_t V3   = V1 + V2;
    localparam word_t V4   = V1 - V3;
    localparam word_t V5   = V3 ^ V4;
    localparam word_t V6   = ($signed(V4) < $signed(V1)) ? 32'd1 : 32'd0;
    localparam word_t V8   = V4 + 32'd100;
    localparam word_t LINK = START_PC + 32'd15 * 32'd4 + 32'd4;
    localparam word_t LOAD_ADDR        = 32'h204;
    localparam int    STORES_EXPECTED  = 6;
    localparam int    LOADS_EXPECTED   = 1;
    localparam int    RETIRED_EXPECTED = 17;

    logic        CLK = 1'b0;
    logic        nrst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    word_t       pwdata;
    word_t       prdata;
    logic        pready;
    logic        pslverr;
    logic        imem_ren;
    word_t       imem_addr;
    word_t       imem_load;
    logic        ihit;
    logic        dmem_ren;
    logic        dmem_wen;
    word_t       dmem_addr;
    word_t       dmem_store;
    word_t       dmem_load;
    logic        dhit;
    logic        halt;
    int unsigned cycles = 0;
    int          stores = 0;
    int          loads = 0;
    word_t       rdata;
    logic        err;

    always #2 CLK = ~CLK;

    sc_datapath sc_datapath_inst (.*);

    tb_memory tb_memory_inst (.*);

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic apb_access(input logic [3:0] addr, input logic wr, input word_t wdata,
                              output word_t rd, output logic slverr);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge CLK);
        penable <= 1'b1;
        // response sampled mid access cycle
        @(negedge CLK);
        rd     = prdata;
        slverr = pslverr;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    function automatic logic store_expected(input word_t addr, input word_t data);
        case (addr)
            32'h200: store_expected = data == V3;
            32'h204: store_expected = data == V4;
            32'h208: store_expected = data == V5;
            32'h20c: store_expected = data == V6;
            32'h210: store_expected = data == V8;
            32'h21c: store_expected = data == LINK;
            default: store_expected = 1'b0;
        endcase
    endfunction

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (dmem_wen && dhit) begin
            stores <= stores + 1;
        end
        if (dmem_ren && dhit) begin
            loads <= loads + 1;
        end
        if (cycles == CYCLE_LIMIT) begin
            stop_with_error("timeout, the program did not halt within the cycle limit");
        end
    end

    assert property (@(posedge CLK) disable iff (!nrst)
        dmem_wen && dhit |-> store_expected(dmem_addr, dmem_store))
        else stop_with_error($sformatf("Fail %0t: store of %h to %h", $time,
                                       dmem_store, dmem_addr));

    // skipped stores after the taken BNE and the JAL
    assert property (@(posedge CLK) disable iff (!nrst)
        dmem_wen |-> dmem_addr != 32'h214 && dmem_addr != 32'h218)
        else stop_with_error($sformatf("Fail %0t: wrong-path store to %h", $time, dmem_addr));

    // only the load-use pair reads data memory
    assert property (@(posedge CLK) disable iff (!nrst) dmem_ren |-> dmem_addr == LOAD_ADDR)
        else stop_with_error($sformatf("Fail %0t: load from %h", $time, dmem_addr));

    assert property (@(posedge CLK) disable iff (!nrst) psel && penable |-> pready)
        else stop_with_error($sformatf("Fail %0t: pready low in access cycle", $time));

    assert property (@(posedge CLK) disable iff (!nrst) halt |-> !imem_ren && !dmem_wen)
        else stop_with_error($sformatf("Fail %0t: memory request after halt", $time));

    assert property (@(posedge CLK) disable iff (!nrst) halt |=> halt)
        else stop_with_error($sformatf("Fail %0t: halt dropped", $time));

    initial begin
        nrst    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 4'h0;
        pwdata  = '0;
        repeat (2) @(posedge CLK);
        nrst <= 1'b1;
        @(negedge CLK);
        assert (!imem_ren && !dmem_ren && !dmem_wen && !halt)
            else stop_with_error($sformatf("Fail %0t: control outputs high after reset",
                                           $time));

        apb_access(REG_STATUS, 1'b0, '0, rdata, err);
        assert (rdata == 32'd0 && !err)
            else stop_with_error($sformatf("Fail %0t: status %h before run", $time, rdata));
        apb_access(REG_START_PC, 1'b1, START_PC, rdata, err);
        apb_access(REG_START_PC, 1'b0, '0, rdata, err);
        assert (rdata == START_PC && !err)
            else stop_with_error($sformatf("Fail %0t: start pc read %h", $time, rdata));
        apb_access(REG_RETIRED, 1'b1, 32'h55, rdata, err);
        assert (err)
            else stop_with_error($sformatf("Fail %0t: no pslverr on retired write", $time));

        apb_access(REG_CTRL, 1'b1, 32'd1, rdata, err);
        while (!halt) begin
            @(posedge CLK);
        end

        apb_access(REG_RETIRED, 1'b0, '0, rdata, err);
        assert (rdata == RETIRED_EXPECTED)
            else stop_with_error($sformatf("Fail %0t: retired count %0d", $time, rdata));
        apb_access(REG_STATUS, 1'b0, '0, rdata, err);
        assert (rdata == 32'd1)
            else stop_with_error($sformatf("Fail %0t: status %h after halt", $time, rdata));
        assert (stores == STORES_EXPECTED)
            else stop_with_error($sformatf("Fail %0t: %0d stores seen", $time, stores));
        assert (loads == LOADS_EXPECTED)
            else stop_with_error($sformatf("Fail %0t: %0d loads seen", $time, loads));

        $display("test passed");
        $finish;
    end

endmodule

/* testbench/tb_memory.sv */
// instruction ROM with the test program and data RAM, both with random hit latency
`timescale 1ns/100ps
module tb_memory (
    input  logic                CLK,
    input  logic                nrst,
    input  logic                imem_ren,
    input  datapath_pkg::word_t imem_addr,
    output datapath_pkg::word_t imem_load,
    output logic                ihit,
    input  logic                dmem_ren,
    input  logic                dmem_wen,
    input  datapath_pkg::word_t dmem_addr,
    input  datapath_pkg::word_t dmem_store,
    output datapath_pkg::word_t dmem_load,
    output logic                dhit
);
    import datapath_pkg::*;

    word_t      rom [64];
    word_t      ram [64];
    logic [1:0] icnt;
    logic [1:0] ilat;
    logic [1:0] dcnt;
    logic [1:0] dlat;
    integer     seed = 32'hffcdca7d;

    function automatic word_t rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input reg_sel_t rd, input reg_sel_t rs1,
                                         input reg_sel_t rs2);
        rtype_word = {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t itype_word(input logic [6:0] op, input logic [2:0] f3,
                                         input reg_sel_t rd, input reg_sel_t rs1,
                                         input logic [11:0] imm);
        itype_word = {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t sw_word(input reg_sel_t rs2, input logic [11:0] imm);
        sw_word = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t bne_word(input reg_sel_t rs1, input reg_sel_t rs2,
                                       input logic [12:0] imm);
        bne_word = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t jal_word(input reg_sel_t rd, input logic [20:0] imm);
        jal_word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            rom[i] = HALT_INSTR;
            ram[i] = {16'hd0a7, 8'(i), 8'(i * 3)};
        end
        rom[0]  = itype_word(7'b0010011, 3'b000, 5'd1, 5'd0, 12'd5);
        rom[1]  = itype_word(7'b0010011, 3'b000, 5'd2, 5'd1, 12'd7);
        rom[2]  = rtype_word(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2);
        rom[3]  = rtype_word(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd3);
        rom[4]  = rtype_word(7'b0000000, 3'b100, 5'd5, 5'd3, 5'd4);
        rom[5]  = rtype_word(7'b0000000, 3'b010, 5'd6, 5'd4, 5'd1);
        rom[6]  = sw_word(5'd3, 12'h200);
        rom[7]  = sw_word(5'd4, 12'h204);
        rom[8]  = sw_word(5'd5, 12'h208);
        rom[9]  = sw_word(5'd6, 12'h20c);
        // load-use pair
        rom[10] = itype_word(7'b0000011, 3'b010, 5'd7, 5'd0, 12'h204);
        rom[11] = itype_word(7'b0010011, 3'b000, 5'd8, 5'd7, 12'd100);
        rom[12] = sw_word(5'd8, 12'h210);
        rom[13] = bne_word(5'd1, 5'd2, 13'd8);
        rom[14] = sw_word(5'd1, 12'h214);
        rom[15] = jal_word(5'd9, 21'd8);
        rom[16] = sw_word(5'd2, 12'h218);
        rom[17] = sw_word(5'd9, 12'h21c);
        rom[18] = HALT_INSTR;
    end

    assign imem_load = rom[imem_addr[7:2]];
    assign dmem_load = ram[dmem_addr[7:2]];
    assign ihit      = imem_ren && (icnt >= ilat);
    assign dhit      = (dmem_ren || dmem_wen) && (dcnt >= dlat);

    // new latency of 0 to 3 cycles drawn after every hit
    always @(posedge CLK or negedge nrst) begin
        if (!nrst) begin
            icnt <= 2'd0;
            ilat <= 2'd0;
            dcnt <= 2'd0;
            dlat <= 2'd0;
        end else begin
            if (ihit) begin
                icnt <= 2'd0;
                ilat <= 2'($random(seed));
            end else if (imem_ren) begin
                icnt <= icnt + 2'd1;
            end else begin
                icnt <= 2'd0;
            end
            if (dhit) begin
                dcnt <= 2'd0;
                dlat <= 2'($random(seed));
            end else if (dmem_ren || dmem_wen) begin
                dcnt <= dcnt + 2'd1;
            end else begin
                dcnt <= 2'd0;
            end
            if (dmem_wen && dhit) begin
                ram[dmem_addr[7:2]] <= dmem_store;
            end
        end
    end

endmodule

/* verilog/sc_datapath.sv */
// top level: fetch and writeback latches, stage wiring, APB and memory ports
`timescale 1ns/100ps
module sc_datapath (
    input  logic                CLK,
    input  logic                nrst,
    // APB slave
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [3:0]          paddr,
    input  datapath_pkg::word_t pwdata,
    output datapath_pkg::word_t prdata,
    output logic                pready,
    output logic                pslverr,
    // instruction memory
    output logic                imem_ren,
    output datapath_pkg::word_t imem_addr,
    input  datapath_pkg::word_t imem_load,
    input  logic                ihit,
    // data memory
    output logic                dmem_ren,
    output logic                dmem_wen,
    output datapath_pkg::word_t dmem_addr,
    output datapath_pkg::word_t dmem_store,
    input  datapath_pkg::word_t dmem_load,
    input  logic                dhit,
    output logic                halt
);
    import datapath_pkg::*;

    logic     run;
    word_t    start_pc;
    logic     retire;
    fetch_t   fetch_out;
    fetch_t   sb_in;
    logic     fetch_valid;
    logic     sb_valid;
    issue_t   issue;
    logic     issue_valid;
    execute_t ex_out;
    execute_t wb_in;
    resolve_t resolve;
    wb_t      wb;
    logic     freeze;
    logic     branch_pending;
    logic     ex_busy;

    dp_control_regs dp_control_regs_inst (
        .CLK, .nrst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .retire, .halt, .prdata, .pready, .pslverr, .run, .start_pc
    );

    fetch_stage fetch_stage_inst (
        .CLK, .nrst, .run, .start_pc, .ihit, .imem_load, .freeze, .halt,
        .resolve, .branch_pending, .imem_ren, .imem_addr, .fetch_out, .fetch_valid
    );

    scoreboard scoreboard_inst (
        .CLK, .nrst,
        .fetch_in    (sb_in),
        .fetch_valid (sb_valid),
        .wb, .resolve, .ex_busy,
        .issue_out   (issue),
        .issue_valid, .freeze, .branch_pending
    );

    execute execute_inst (
        .CLK, .nrst,
        .issue_in (issue),
        .issue_valid, .dmem_load, .dhit, .ex_out, .resolve, .ex_busy,
        .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store
    );

    writeback writeback_inst (
        .CLK, .nrst, .wb_in, .resolve, .wb, .retire, .halt
    );

    // fetch latch flushed by a taken branch ahead of freeze
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            sb_valid <= 1'b0;
        end else if (resolve.miss) begin
            sb_valid <= 1'b0;
        end else if (!freeze) begin
            sb_valid <= fetch_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!freeze) begin
            sb_in <= fetch_out;
        end
    end

    // writeback latch
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            wb_in <= '0;
        end else begin
            wb_in <= ex_out;
        end
    end

endmodule

/* verilog/dp_control_regs.sv */
// APB control registers: run bit, start PC, retired count and halt status
`timescale 1ns/100ps
module dp_control_regs (
    input  logic                CLK,
    input  logic                nrst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [3:0]          paddr,
    input  datapath_pkg::word_t pwdata,
    input  logic                retire,
    input  logic                halt,
    output datapath_pkg::word_t prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                run,
    output datapath_pkg::word_t start_pc
);
    import datapath_pkg::*;

    word_t retired;
    logic  access;
    logic  bad_addr;
    logic  wr_en;

    assign access   = psel && penable;
    assign bad_addr = !(paddr inside {REG_CTRL, REG_START_PC, REG_RETIRED, REG_STATUS});

    // retired count and status are read only
    assign pslverr = access && (bad_addr
                     || (pwrite && (paddr == REG_RETIRED || paddr == REG_STATUS)));
    assign wr_en   = access && pwrite && !pslverr;
    assign pready  = 1'b1;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            run      <= 1'b0;
            start_pc <= '0;
            retired  <= '0;
        end else begin
            if (wr_en && paddr == REG_CTRL) begin
                run <= pwdata[0];
            end
            if (wr_en && paddr == REG_START_PC) begin
                start_pc <= pwdata;
            end
            if (retire) begin
                retired <= retired + 32'd1;
            end
        end
    end

    always_comb begin
        case (paddr)
            REG_CTRL:     prdata = {31'b0, run};
            REG_START_PC: prdata = start_pc;
            REG_RETIRED:  prdata = retired;
            REG_STATUS:   prdata = {31'b0, halt};
            default:      prdata = '0;
        endcase
    end

endmodule

/* verilog/writeback.sv */
// writeback stage: commit selection, wrong-path squash, retire pulse and halt
`timescale 1ns/100ps
module writeback (
    input  logic                   CLK,
    input  logic                   nrst,
    input  datapath_pkg::execute_t wb_in,
    input  datapath_pkg::resolve_t resolve,
    output datapath_pkg::wb_t      wb,
    output logic                   retire,
    output logic                   halt
);
    import datapath_pkg::*;

    logic commit;

    // a speculative result dies with the branch that missed
    assign commit = wb_in.done && !(wb_in.spec && resolve.miss);
    assign retire = commit;

    // stores, branches and halt carry rd zero
    assign wb.reg_en  = commit && wb_in.reg_sel != '0 && !wb_in.is_halt;
    assign wb.reg_sel = wb_in.reg_sel;
    assign wb.wdat    = wb_in.wdat;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            halt <= 1'b0;
        end else if (commit && wb_in.is_halt) begin
            halt <= 1'b1;
        end
    end

endmodule

/* verilog/execute.sv */
// execute stage: ALU, branch resolution and load/store unit
`timescale 1ns/100ps
module execute (
    input  logic                   CLK,
    input  logic                   nrst,
    input  datapath_pkg::issue_t   issue_in,
    input  logic                   issue_valid,
    input  datapath_pkg::word_t    dmem_load,
    input  logic                   dhit,
    output datapath_pkg::execute_t ex_out,
    output datapath_pkg::resolve_t resolve,
    output logic                   ex_busy,
    output logic                   dmem_ren,
    output logic                   dmem_wen,
    output datapath_pkg::word_t    dmem_addr,
    output datapath_pkg::word_t    dmem_store
);
    import datapath_pkg::*;

    word_t alu_res;
    word_t link;
    logic  taken;
    logic  is_ctrl;

    always_comb begin
        case (issue_in.alu_op)
            ALU_ADD: alu_res = issue_in.rdat1 + issue_in.rdat2;
            ALU_SUB: alu_res = issue_in.rdat1 - issue_in.rdat2;
            ALU_AND: alu_res = issue_in.rdat1 & issue_in.rdat2;
            ALU_OR:  alu_res = issue_in.rdat1 | issue_in.rdat2;
            ALU_XOR: alu_res = issue_in.rdat1 ^ issue_in.rdat2;
            ALU_SLT: alu_res = {31'b0, $signed(issue_in.rdat1) < $signed(issue_in.rdat2)};
            default: alu_res = '0;
        endcase
    end

    // branch unit checks the not-taken guess of fetch
    assign link    = issue_in.pc + 32'd4;
    assign is_ctrl = issue_valid && (issue_in.fu_sel == FU_BRANCH || issue_in.fu_sel == FU_JUMP);

    always_comb begin
        if (issue_in.fu_sel == FU_JUMP) begin
            taken = 1'b1;
        end else if (issue_in.alu_op == ALU_XOR) begin
            taken = alu_res != '0;
        end else begin
            taken = alu_res == '0;
        end
    end

    assign resolve.resolved   = is_ctrl;
    assign resolve.miss       = is_ctrl && taken;
    assign resolve.correct_pc = issue_in.pc + issue_in.imm;

    // load/store unit holds its request until dhit
    assign dmem_ren   = issue_valid && issue_in.fu_sel == FU_LOAD;
    assign dmem_wen   = issue_valid && issue_in.fu_sel == FU_STORE;
    assign dmem_addr  = issue_in.rdat1 + issue_in.imm;
    assign dmem_store = issue_in.rdat2;
    assign ex_busy    = (dmem_ren || dmem_wen) && !dhit;

    always_comb begin
        ex_out.done    = issue_valid && !ex_busy;
        ex_out.reg_sel = issue_in.rd;
        ex_out.spec    = issue_in.spec;
        ex_out.is_halt = issue_in.fu_sel == FU_HALT;
        case (issue_in.fu_sel)
            FU_LOAD: ex_out.wdat = dmem_load;
            FU_JUMP: ex_out.wdat = link;
            default: ex_out.wdat = alu_res;
        endcase
    end

    assert property (@(posedge CLK) disable iff (!nrst) !(dmem_ren && dmem_wen));

    // the held issue register keeps the data request steady until dhit
    assert property (@(posedge CLK) disable iff (!nrst)
        ex_busy |=> $stable(dmem_addr) && $stable({dmem_ren, dmem_wen}));

endmodule

/* verilog/scoreboard.sv */
// scoreboard: decode, register file, busy bits and single-instruction issue
`timescale 1ns/100ps
module scoreboard (
    input  logic                   CLK,
    input  logic                   nrst,
    input  datapath_pkg::fetch_t   fetch_in,
    input  logic                   fetch_valid,
    input  datapath_pkg::wb_t      wb,
    input  datapath_pkg::resolve_t resolve,
    input  logic                   ex_busy,
    output datapath_pkg::issue_t   issue_out,
    output logic                   issue_valid,
    output logic                   freeze,
    output logic                   branch_pending
);
    import datapath_pkg::*;

    word_t       regs [32];
    logic [31:0] busy;
    logic        spec_clear;
    logic        halt_seen;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_sel_t   rs1;
    reg_sel_t   rs2;
    reg_sel_t   rd;
    reg_sel_t   issue_rd;
    word_t      imm;
    word_t      rdat1;
    word_t      rdat2;
    fu_sel_t    fu_sel;
    alu_op_t    alu_op;
    logic       use_rs1;
    logic       use_rs2;
    logic       writes_rd;
    logic       spec_live;
    logic       stall;
    logic       fire;

    function automatic alu_op_t decode_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  decode_alu = alt ? ALU_SUB : ALU_ADD;
            3'b010:  decode_alu = ALU_SLT;
            3'b100:  decode_alu = ALU_XOR;
            3'b110:  decode_alu = ALU_OR;
            3'b111:  decode_alu = ALU_AND;
            default: decode_alu = ALU_ADD;
        endcase
    endfunction

    assign opcode = fetch_in.instr[6:0];
    assign funct3 = fetch_in.instr[14:12];
    assign rd     = fetch_in.instr[11:7];
    assign rs1    = fetch_in.instr[19:15];
    assign rs2    = fetch_in.instr[24:20];

    always_comb begin
        fu_sel    = FU_ALU;
        alu_op    = ALU_ADD;
        imm       = '0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        writes_rd = 1'b0;
        if (fetch_in.instr == HALT_INSTR) begin
            fu_sel = FU_HALT;
        end else begin
            case (opcode)
                OP_REG: begin
                    alu_op    = decode_alu(funct3, fetch_in.instr[30]);
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                    writes_rd = 1'b1;
                end
                OP_IMM: begin
                    alu_op    = decode_alu(funct3, 1'b0);
                    imm       = {{20{fetch_in.instr[31]}}, fetch_in.instr[31:20]};
                    use_rs1   = 1'b1;
                    writes_rd = 1'b1;
                end
                OP_LOAD: begin
                    fu_sel    = FU_LOAD;
                    imm       = {{20{fetch_in.instr[31]}}, fetch_in.instr[31:20]};
                    use_rs1   = 1'b1;
                    writes_rd = 1'b1;
                end
                OP_STORE: begin
                    fu_sel  = FU_STORE;
                    imm     = {{20{fetch_in.instr[31]}}, fetch_in.instr[31:25],
                               fetch_in.instr[11:7]};
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
                OP_BRANCH: begin
                    // BEQ compares by subtract, BNE by xor
                    fu_sel  = FU_BRANCH;
                    alu_op  = funct3[0] ? ALU_XOR : ALU_SUB;
                    imm     = {{19{fetch_in.instr[31]}}, fetch_in.instr[31], fetch_in.instr[7],
                               fetch_in.instr[30:25], fetch_in.instr[11:8], 1'b0};
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
                OP_JAL: begin
                    fu_sel    = FU_JUMP;
                    imm       = {{11{fetch_in.instr[31]}}, fetch_in.instr[31],
                                 fetch_in.instr[19:12], fetch_in.instr[20],
                                 fetch_in.instr[30:21], 1'b0};
                    writes_rd = 1'b1;
                end
                default: begin
                    // unknown opcodes issue as a no-op
                    fu_sel = FU_ALU;
                end
            endcase
        end
    end

    // x0 reads as zero and is never written
    assign rdat1    = (rs1 == '0) ? '0 : regs[rs1];
    assign rdat2    = (rs2 == '0) ? '0 : regs[rs2];
    assign issue_rd = writes_rd ? rd : '0;

    // spec drops once the older branch resolves not taken
    assign spec_live = fetch_in.spec && !spec_clear && !(resolve.resolved && !resolve.miss);

    // waits on RAW and WAW hazards, memory wait and wrong-path memory ops
    assign stall = ex_busy || halt_seen
                   || (use_rs1 && busy[rs1])
                   || (use_rs2 && busy[rs2])
                   || busy[issue_rd]
                   || (spec_live && (fu_sel == FU_LOAD || fu_sel == FU_STORE));

    assign freeze         = fetch_valid && stall;
    assign fire           = fetch_valid && !stall && !resolve.miss;
    assign branch_pending = fetch_valid && (fu_sel == FU_BRANCH || fu_sel == FU_JUMP);

    always_ff @(posedge CLK) begin
        if (wb.reg_en) begin
            regs[wb.reg_sel] <= wb.wdat;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy        <= '0;
            spec_clear  <= 1'b0;
            halt_seen   <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            if (wb.reg_en) begin
                busy[wb.reg_sel] <= 1'b0;
            end
            if (fire && issue_rd != '0) begin
                busy[issue_rd] <= 1'b1;
            end
            spec_clear <= freeze && (spec_clear || (resolve.resolved && !resolve.miss));
            halt_seen  <= halt_seen || (fire && fu_sel == FU_HALT);
            if (!ex_busy) begin
                issue_valid <= fire;
            end
        end
    end

    // issue register holds while execute waits on memory
    always_ff @(posedge CLK) begin
        if (!ex_busy) begin
            issue_out.fu_sel <= fu_sel;
            issue_out.alu_op <= alu_op;
            issue_out.rd     <= issue_rd;
            issue_out.rdat1  <= rdat1;
            // immediate ALU ops take the immediate as second operand
            issue_out.rdat2  <= (opcode == OP_IMM) ? imm : rdat2;
            issue_out.imm    <= imm;
            issue_out.pc     <= fetch_in.pc;
            issue_out.spec   <= spec_live;
        end
    end

    // no write to an issued source may still be on its way to writeback
    assert property (@(posedge CLK) disable iff (!nrst)
        fire |=> !(wb.reg_en && $past(use_rs1) && wb.reg_sel == $past(rs1))
                 && !(wb.reg_en && $past(use_rs2) && wb.reg_sel == $past(rs2)));

endmodule

/* verilog/fetch_stage.sv */
// fetch stage: program counter, instruction requests and redirect on a taken branch
`timescale 1ns/100ps
module fetch_stage (
    input  logic                   CLK,
    input  logic                   nrst,
    input  logic                   run,
    input  datapath_pkg::word_t    start_pc,
    input  logic                   ihit,
    input  datapath_pkg::word_t    imem_load,
    input  logic                   freeze,
    input  logic                   halt,
    input  datapath_pkg::resolve_t resolve,
    input  logic                   branch_pending,
    output logic                   imem_ren,
    output datapath_pkg::word_t    imem_addr,
    output datapath_pkg::fetch_t   fetch_out,
    output logic                   fetch_valid
);
    import datapath_pkg::*;

    word_t pc;
    word_t cur_pc;
    logic  run_q;
    logic  accept;

    // first cycle of a run requests straight from start_pc
    assign cur_pc    = run_q ? pc : start_pc;
    assign imem_ren  = run && !halt;
    assign imem_addr = cur_pc;

    // a hit under freeze is dropped, the request stays up and repeats
    assign accept      = imem_ren && ihit && !freeze && !resolve.miss;
    assign fetch_valid = accept;

    assign fetch_out.instr = imem_load;
    assign fetch_out.pc    = cur_pc;
    assign fetch_out.spec  = branch_pending;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            run_q <= 1'b0;
            pc    <= '0;
        end else begin
            run_q <= run;
            if (resolve.miss) begin
                pc <= resolve.correct_pc;
            end else if (accept) begin
                pc <= cur_pc + 32'd4;
            end else if (!run_q) begin
                pc <= start_pc;
            end
        end
    end

    // request address held until the memory answers
    assert property (@(posedge CLK) disable iff (!nrst)
        imem_ren && !ihit && !resolve.miss |=> $stable(imem_addr) || !imem_ren);

endmodule

/* verilog/datapath_pkg.sv */
// ISA constants, opcode and ALU enums, APB register map and pipeline structs
package datapath_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_sel_t;

    // RV32I major opcodes of the supported subset
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // all-ones word stops the machine
    localparam word_t HALT_INSTR = 32'hffff_ffff;

    // APB register offsets
    localparam logic [3:0] REG_CTRL     = 4'h0;
    localparam logic [3:0] REG_START_PC = 4'h4;
    localparam logic [3:0] REG_RETIRED  = 4'h8;
    localparam logic [3:0] REG_STATUS   = 4'hc;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [2:0] {
        FU_ALU,
        FU_BRANCH,
        FU_LOAD,
        FU_STORE,
        FU_JUMP,
        FU_HALT
    } fu_sel_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        logic  spec;
    } fetch_t;

    typedef struct packed {
        fu_sel_t  fu_sel;
        alu_op_t  alu_op;
        reg_sel_t rd;
        word_t    rdat1;
        word_t    rdat2;
        word_t    imm;
        word_t    pc;
        logic     spec;
    } issue_t;

    typedef struct packed {
        logic     done;
        word_t    wdat;
        reg_sel_t reg_sel;
        logic     spec;
        logic     is_halt;
    } execute_t;

    typedef struct packed {
        logic  resolved;
        logic  miss;
        word_t correct_pc;
    } resolve_t;

    typedef struct packed {
        logic     reg_en;
        reg_sel_t reg_sel;
        word_t    wdat;
    } wb_t;

endpackage
